//--- sim.f
+incdir+.
sr_pkg.sv
sr_req_pipe.sv
sr_app_regs.sv
sr_resp_tree.sv
sr_fabric_top.sv
sr_fabric_chk.sv
tb_sr_fabric.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

( verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_sr_fabric --Mdir obj_dir -o sim_tb &&
	./obj_dir/sim_tb ) > sim.log 2>&1

grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed, see sim.log"; exit 1; }

//--- tb_sr_fabric.sv
// Soft-register fabric testbench: random host traffic checked against a register model
`include "sr_config.svh"

module tb_sr_fabric;
	import sr_pkg::*;

	// Host read to host response, pipeline + app + tree levels
	localparam int RESP_LAT = `SR_REQ_STAGES + 1 + $clog2(`SR_NUM_APPS);
	localparam int N_STORE = (1 << `SR_REG_IDX_W) - 1;

	// Operations per phase, one request slot per cycle
	localparam int N_RESET_READS = `SR_NUM_APPS * (N_STORE + 1);
	localparam int N_RANDOM = 300;
	localparam int N_BURST = 64;
	localparam int N_COUNT = `SR_NUM_APPS * 8;
	localparam int N_ALIAS = `SR_NUM_APPS * 2;
	localparam int N_OPS = N_RESET_READS + N_RANDOM + N_BURST + N_COUNT + N_ALIAS;
	localparam int WATCHDOG_TIME = (N_OPS + 20) * 10;

	typedef struct packed {
		logic [31:0] due;
		sr_data_t    data;
	} exp_entry_t;

	logic       global_clk;
	logic       global_rst_n;
	sr_req_t    host_req;
	sr_resp_t   host_resp;
	logic [31:0] cyc = '0;
	logic [31:0] lcg_state = 32'h606d2380;

	// Reference model state
	sr_data_t   model_regs [`SR_NUM_APPS][N_STORE];
	sr_data_t   model_cnt [`SR_NUM_APPS];
	exp_entry_t exp_q [$];

	sr_fabric_top i_dut (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.host_req(host_req),
		.host_resp(host_resp)
	);

	initial begin
		global_clk = 1'b0;
		forever #5 global_clk = ~global_clk;
	end

	always @(posedge global_clk) cyc <= cyc + 32'd1;

	// ------------------------------
	// Helpers
	// ------------------------------

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic sr_addr_t make_addr(input logic [2:0] upper, input app_id_t app,
			input reg_idx_t idx);
		return {upper, app, idx};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Present one request slot and update the model in request order
	task automatic issue_req(input logic vld, input logic wr, input sr_addr_t addr,
			input sr_data_t data);
		app_id_t    app;
		reg_idx_t   idx;
		exp_entry_t ent;
		@(posedge global_clk);
		#1;
		host_req.valid = vld;
		host_req.write = wr;
		host_req.addr = addr;
		host_req.data = data;
		app = addr[`SR_REG_IDX_W +: `SR_APP_ID_W];
		idx = addr[`SR_REG_IDX_W-1:0];
		if (vld && wr) begin
			if (idx == reg_idx_t'(N_STORE)) begin
				model_cnt[app] = '0;
			end else begin
				model_regs[app][idx] = data;
				model_cnt[app] = model_cnt[app] + 32'd1;
			end
		end else if (vld) begin
			ent.due = cyc + RESP_LAT;
			ent.data = (idx == reg_idx_t'(N_STORE)) ? model_cnt[app] : model_regs[app][idx];
			exp_q.push_back(ent);
		end
	endtask

	// ------------------------------
	// Response checker
	// ------------------------------

	// Sampled mid-cycle, away from the edge where drive and DUT update
	always @(negedge global_clk) begin
		if (!global_rst_n) begin
			if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
				check_value("host_resp valid", 32'(host_resp.valid), 32'd1);
				check_value("host_resp data", host_resp.data, exp_q[0].data);
				void'(exp_q.pop_front());
			end else begin
				check_value("unexpected host_resp valid", 32'(host_resp.valid), 32'd0);
			end
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------
	// Stimulus
	// ------------------------------

	initial begin
		logic [31:0] r;
		app_id_t     app;
		reg_idx_t    idx;
		global_rst_n = 1'b1;
		host_req = '0;
		for (int a = 0; a < `SR_NUM_APPS; a++) begin
			model_cnt[a] = '0;
			for (int i = 0; i < N_STORE; i++) begin
				model_regs[a][i] = '0;
			end
		end
		repeat (3) @(posedge global_clk);
		#1;
		global_rst_n = 1'b0;

		// Every register of every app reads zero after reset
		for (int a = 0; a < `SR_NUM_APPS; a++) begin
			for (int i = 0; i <= N_STORE; i++) begin
				issue_req(1'b1, 1'b0, make_addr(3'(next_rand() >> 29), app_id_t'(a),
					reg_idx_t'(i)), '0);
			end
		end

		// Mixed writes, reads and idle slots, upper address bits random
		for (int n = 0; n < N_RANDOM; n++) begin
			r = next_rand();
			app = r[20:19];
			idx = r[18:16];
			if (r[31:28] < 4'd6) begin
				issue_req(1'b1, 1'b1, make_addr(r[15:13], app, idx), next_rand());
			end else if (r[31:28] < 4'd13) begin
				issue_req(1'b1, 1'b0, make_addr(r[15:13], app, idx), next_rand());
			end else begin
				issue_req(1'b0, r[12], make_addr(r[15:13], app, idx), next_rand());
			end
		end

		// Back-to-back reads
		for (int n = 0; n < N_BURST; n++) begin
			r = next_rand();
			issue_req(1'b1, 1'b0, make_addr(r[15:13], r[20:19], r[18:16]), '0);
		end

		// Write counter: clear, count a few writes, read back
		for (int a = 0; a < `SR_NUM_APPS; a++) begin
			issue_req(1'b1, 1'b1, make_addr(3'b000, app_id_t'(a), 3'd7), next_rand());
			issue_req(1'b1, 1'b0, make_addr(3'b000, app_id_t'(a), 3'd7), '0);
			for (int w = 0; w < 5; w++) begin
				idx = reg_idx_t'(next_rand() % N_STORE);
				issue_req(1'b1, 1'b1, make_addr(3'b011, app_id_t'(a), idx), next_rand());
			end
			issue_req(1'b1, 1'b0, make_addr(3'b110, app_id_t'(a), 3'd7), '0);
		end

		// Aliases through the ignored top address bits
		for (int a = 0; a < `SR_NUM_APPS; a++) begin
			idx = reg_idx_t'((a + 1) % N_STORE);
			issue_req(1'b1, 1'b1, make_addr(3'b111, app_id_t'(a), idx), next_rand());
			issue_req(1'b1, 1'b0, make_addr(3'b000, app_id_t'(a), idx), '0);
		end

		issue_req(1'b0, 1'b0, '0, '0);
		while (exp_q.size() != 0) begin
			@(posedge global_clk);
		end
		repeat (2) @(posedge global_clk);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- sr_fabric_chk.sv
// Soft-register fabric checker: response timing assertions on the top-level ports
module sr_fabric_chk (
	input logic             global_clk,
	input logic             global_rst_n,
	input sr_pkg::sr_req_t  host_req,
	input sr_pkg::sr_resp_t host_resp
);
	import sr_pkg::*;

	// One bit per cycle of read latency, cleared with the pipeline
	logic [5:0] rd_hist;

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			rd_hist <= '0;
		end else begin
			rd_hist <= {rd_hist[4:0], host_req.valid && !host_req.write};
		end
	end

	// ------------------------------
	// Properties
	// ------------------------------

	a_quiet_in_reset: assert property (@(posedge global_clk)
		$past(global_rst_n) |-> !host_resp.valid)
		else $error("host_resp valid high during reset");

	a_quiet_after_reset: assert property (@(posedge global_clk)
		$past(global_rst_n, 2) |-> !host_resp.valid)
		else $error("host_resp valid high in the cycle after reset");

	a_resp_has_read: assert property (@(posedge global_clk)
		host_resp.valid |-> rd_hist[5])
		else $error("host_resp valid without a read six cycles earlier");

	a_read_gets_resp: assert property (@(posedge global_clk)
		rd_hist[5] |-> host_resp.valid)
		else $error("read not answered six cycles later");

endmodule

bind sr_fabric_top sr_fabric_chk i_chk (
	.global_clk(global_clk),
	.global_rst_n(global_rst_n),
	.host_req(host_req),
	.host_resp(host_resp)
);

//--- sr_fabric_top.sv
// Soft-register fabric top: request pipeline, app broadcast and response merge tree
`include "sr_config.svh"

module sr_fabric_top (
	input  logic             global_clk,
	input  logic             global_rst_n,
	input  sr_pkg::sr_req_t  host_req,
	output sr_pkg::sr_resp_t host_resp
);
	import sr_pkg::*;

	// Broadcast request, same copy to every app
	sr_req_t app_req;

	// One response slot per app
	sr_resp_t [`SR_NUM_APPS-1:0] app_resp;

	genvar app_num;

	// ------------------------------
	// Request pipeline
	// ------------------------------

	sr_req_pipe #(
		.STAGES(`SR_REQ_STAGES)
	) i_req_pipe (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.req_in(host_req),
		.req_out(app_req)
	);

	// ------------------------------
	// Apps
	// ------------------------------

	// Each app decodes its own slice from the shared request
	for (app_num = 0; app_num < `SR_NUM_APPS; app_num++) begin : g_app
		sr_app_regs #(
			.APP_ID(app_num)
		) i_app (
			.global_clk(global_clk),
			.global_rst_n(global_rst_n),
			.req(app_req),
			.resp(app_resp[app_num])
		);
	end

	// ------------------------------
	// Response merge
	// ------------------------------

	sr_resp_tree #(
		.N_LEAVES(`SR_NUM_APPS)
	) i_resp_tree (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.leaf_resp(app_resp),
		.root_resp(host_resp)
	);

endmodule

//--- sr_resp_tree.sv
// Response merge tree: registered binary OR levels from the apps to the host
module sr_resp_tree #(
	parameter int N_LEAVES = 4
) (
	input  logic                            global_clk,
	input  logic                            global_rst_n,
	input  sr_pkg::sr_resp_t [N_LEAVES-1:0] leaf_resp,
	output sr_pkg::sr_resp_t                root_resp
);
	import sr_pkg::*;

	// One register level per halving
	localparam int LEVELS = $clog2(N_LEAVES);

	genvar lv;

	// ------------------------------
	// Tree levels
	// ------------------------------

	for (lv = 0; lv < LEVELS; lv++) begin : g_level
		// Nodes produced by this level
		localparam int N_OUT = N_LEAVES >> (lv + 1);

		sr_resp_t [2*N_OUT-1:0] node_in;
		sr_resp_t [N_OUT-1:0]   node_q;

		// Leaves feed the first level, later levels take the one below
		if (lv == 0) begin : g_leaf
			assign node_in = leaf_resp;
		end else begin : g_inner
			assign node_in = g_level[lv-1].node_q;
		end

		// At most one input of a pair is nonzero in any cycle
		always_ff @(posedge global_clk) begin
			if (global_rst_n) begin
				node_q <= '0;
			end else begin
				for (int i = 0; i < N_OUT; i++) begin
					node_q[i] <= node_in[2*i] | node_in[2*i+1];
				end
			end
		end
	end

	// ------------------------------
	// Root
	// ------------------------------

	// Single node left after the last level
	assign root_resp = g_level[LEVELS-1].node_q[0];

endmodule

//--- sr_app_regs.sv
// Application register block: address slice match, storage, write counter, read response
module sr_app_regs #(
	parameter int APP_ID = 0
) (
	input  logic             global_clk,
	input  logic             global_rst_n,
	input  sr_pkg::sr_req_t  req,
	output sr_pkg::sr_resp_t resp
);
	import sr_pkg::*;

	// Address field positions follow the typedef widths
	localparam int IDX_W = $bits(reg_idx_t);
	localparam int ID_W = $bits(app_id_t);

	// Top index is the write counter, the rest are storage
	localparam int N_STORE = (1 << IDX_W) - 1;
	localparam reg_idx_t CNT_IDX = reg_idx_t'(N_STORE);
	localparam app_id_t MY_ID = app_id_t'(APP_ID);

	reg_idx_t idx;
	app_id_t  sel;
	logic     hit;
	logic     wr_hit;
	logic     rd_hit;
	sr_data_t regs_q [N_STORE];
	sr_data_t wr_cnt_q;
	sr_data_t rd_data;
	sr_resp_t resp_q;

	// ------------------------------
	// Address decode
	// ------------------------------

	assign idx = req.addr[IDX_W-1:0];
	assign sel = req.addr[IDX_W +: ID_W];

	// Only our slice of the address space, bits above select ignored
	assign hit = req.valid && (sel == MY_ID);
	assign wr_hit = hit && req.write;
	assign rd_hit = hit && !req.write;

	// ------------------------------
	// Storage and write counter
	// ------------------------------

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int i = 0; i < N_STORE; i++) begin
				regs_q[i] <= '0;
			end
			wr_cnt_q <= '0;
		end else if (wr_hit) begin
			if (idx == CNT_IDX) begin
				// Writing the counter index clears it, data is dropped
				wr_cnt_q <= '0;
			end else begin
				regs_q[idx] <= req.data;
				// Wraps at the full data width
				wr_cnt_q <= wr_cnt_q + 1'b1;
			end
		end
	end

	// ------------------------------
	// Read path
	// ------------------------------

	always_comb begin
		if (idx == CNT_IDX) begin
			rd_data = wr_cnt_q;
		end else begin
			rd_data = regs_q[idx];
		end
	end

	// Idle cycles keep every response bit low for the OR merge
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			resp_q <= '0;
		end else begin
			resp_q.valid <= rd_hit;
			resp_q.data  <= rd_hit ? rd_data : '0;
		end
	end

	assign resp = resp_q;

endmodule

//--- sr_req_pipe.sv
// Soft-register request pipeline: fixed chain of registers toward the apps
module sr_req_pipe #(
	parameter int STAGES = 1
) (
	input  logic            global_clk,
	input  logic            global_rst_n,
	input  sr_pkg::sr_req_t req_in,
	output sr_pkg::sr_req_t req_out
);
	import sr_pkg::*;

	// One independent request per stage
	sr_req_t stage_q [STAGES];

	// ------------------------------
	// Stage registers
	// ------------------------------

	// Reset is synchronous and active high
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= req_in;
			for (int i = 1; i < STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// Last stage feeds the app broadcast
	assign req_out = stage_q[STAGES-1];

endmodule

//--- sr_pkg.sv
// Soft-register fabric types: address and data vectors, request and response structs
`include "sr_config.svh"

package sr_pkg;

	// ------------------------------
	// Plain vectors
	// ------------------------------

	// Word address, [2:0] register index, [4:3] app select, [7:5] unused
	typedef logic [`SR_ADDR_W-1:0] sr_addr_t;

	// Register value
	typedef logic [`SR_DATA_W-1:0] sr_data_t;

	// Register index within one app
	typedef logic [`SR_REG_IDX_W-1:0] reg_idx_t;

	// App number
	typedef logic [`SR_APP_ID_W-1:0] app_id_t;

	// ------------------------------
	// Bus structs
	// ------------------------------

	// Host request, valid is a single-cycle strobe
	typedef struct packed {
		logic     valid;
		logic     write;
		sr_addr_t addr;
		sr_data_t data;
	} sr_req_t;

	// Read response, all zeros when idle so responses can be ORed
	typedef struct packed {
		logic     valid;
		sr_data_t data;
	} sr_resp_t;

endpackage

//--- sr_config.svh
// Soft-register fabric build parameters: pipeline depth, app count and field widths
`ifndef SR_CONFIG_SVH
`define SR_CONFIG_SVH

// ------------------------------
// Request path
// ------------------------------

// Register stages between the host port and the app broadcast
`define SR_REQ_STAGES 3

// Number of application register blocks, power of two only
`define SR_NUM_APPS 4

// ------------------------------
// Bus and field widths
// ------------------------------

// Word address, bits above the app select are ignored
`define SR_ADDR_W 8

// Register data
`define SR_DATA_W 32

// Register index within one app, lowest address bits
`define SR_REG_IDX_W 3

// App select, directly above the register index
`define SR_APP_ID_W 2

`endif
